//--- Makefile
VERILATOR ?= verilator
TOP ?= gameTopTb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
+incdir+src
src/videoPkg.sv
src/gamePkg.sv
src/vgaTiming.sv
src/playerLogic.sv
src/shotLogic.sv
src/birdLogic.sv
src/spriteRenderer.sv
src/collisionDetect.sv
src/gameTop.sv
tests/gameTopTb.sv

//--- src/birdLogic.sv
`timescale 1ns/1ns
`default_nettype none
`include "game_defs.svh"

module birdLogic #(
	parameter videoPkg::coord_t START_X = 11'sd0,
	parameter videoPkg::coord_t START_Y = 11'sd0
) (
	input logic clk,
	input logic reset,
	input logic frameStart,
	input logic kill,
	output gamePkg::objPos_t pos
);

	localparam videoPkg::coord_t step = videoPkg::coord_t'(`BIRD_STEP);
	localparam videoPkg::coord_t maxX = videoPkg::coord_t'(`H_ACTIVE - `OBJ_SIZE);

	videoPkg::coord_t x;
	videoPkg::coord_t nextX;
	logic goRight;

	assign nextX = goRight ? x + step : x - step;

	always_ff @(posedge clk) begin
		if (reset) begin
			x <= START_X;
			goRight <= 1'b1;
		end else if (frameStart) begin
			if (kill) begin
				x <= START_X; // Back to the start, heading right
				goRight <= 1'b1;
			end else if (nextX < 11'sd0 || nextX > maxX) begin
				goRight <= !goRight; // Turn around and hold for this frame
			end else begin
				x <= nextX;
			end
		end
	end

	assign pos = '{active: 1'b1, xy: '{x: x, y: START_Y}};

endmodule

`default_nettype wire

//--- src/collisionDetect.sv
`timescale 1ns/1ns
`default_nettype none
`include "game_defs.svh"

module collisionDetect (
	input logic clk,
	input logic reset,
	input logic frameStart,
	input logic active,
	input logic [`NUM_SHOTS-1:0] shotHit,
	input logic [`NUM_BIRDS-1:0] birdHit,
	output logic [`NUM_SHOTS-1:0] shotKill,
	output logic [`NUM_BIRDS-1:0] birdKill,
	output logic [1:0] scoreInc
);

	logic [`NUM_SHOTS-1:0] shotSticky;
	logic [`NUM_BIRDS-1:0] birdSticky;
	logic anyShot;
	logic anyBird;

	assign anyShot = active && (|shotHit);
	assign anyBird = active && (|birdHit);

	// Hits collect over the visible area and are handed over at frame start
	always_ff @(posedge clk) begin
		if (reset || frameStart) begin
			shotSticky <= '0;
			birdSticky <= '0;
		end else begin
			shotSticky <= shotSticky | (shotHit & {`NUM_SHOTS{anyBird}});
			birdSticky <= birdSticky | (birdHit & {`NUM_BIRDS{anyShot}});
		end
	end

	assign shotKill = shotSticky & {`NUM_SHOTS{frameStart}};
	assign birdKill = birdSticky & {`NUM_BIRDS{frameStart}};
	assign scoreInc = 2'($countones(birdKill)); // One point per bird

endmodule

`default_nettype wire

//--- src/gamePkg.sv
`default_nettype none

package gamePkg;

	typedef enum logic {
		IDLE,
		ACTIVE
	} objState_t;

	// Winning layer of a pixel
	typedef enum logic [1:0] {
		NONE,
		PLAYER,
		SHOT,
		BIRD
	} objKind_t;

	typedef struct packed {
		logic active;
		videoPkg::pixelPos_t xy; // Top left corner
	} objPos_t;

	typedef struct packed {
		logic left;
		logic right;
		logic shoot;
	} controls_t;

endpackage

`default_nettype wire

//--- src/gameTop.sv
`timescale 1ns/1ns
`default_nettype none
`include "game_defs.svh"

module gameTop (
	input logic clk,
	input logic reset,
	input gamePkg::controls_t controls,
	output videoPkg::rgb_t rgb,
	output logic hsync,
	output logic vsync,
	output logic blank,
	output logic [7:0] score
);

	localparam int birdX0 = 8;
	localparam int birdDX = 28;

	videoPkg::pixelPos_t pixel;
	logic active;
	logic hsyncRaw;
	logic vsyncRaw;
	logic frameStart;

	gamePkg::objPos_t playerPos;
	gamePkg::objPos_t [`NUM_SHOTS-1:0] shotPos;
	gamePkg::objPos_t [`NUM_BIRDS-1:0] birdPos;

	logic [`NUM_SHOTS-1:0] shotHit;
	logic [`NUM_SHOTS-1:0] shotKill;
	logic [`NUM_SHOTS-1:0] freeShots;
	logic [`NUM_SHOTS-1:0] deploy;
	logic [`NUM_BIRDS-1:0] birdHit;
	logic [`NUM_BIRDS-1:0] birdKill;
	logic [1:0] scoreInc;
	logic shootLast;
	logic shootEdge;

	vgaTiming timing (.clk, .reset, .pixel, .active, .hsyncRaw, .vsyncRaw, .frameStart);

	playerLogic player (.clk, .reset, .frameStart, .controls, .pos(playerPos));

	// ====================
	// Shots and birds
	for (genvar i = 0; i < `NUM_SHOTS; i++) begin : genShots
		assign freeShots[i] = !shotPos[i].active;

		shotLogic shot (
			.clk,
			.reset,
			.frameStart,
			.deploy(deploy[i]),
			.kill(shotKill[i]),
			.playerPos,
			.pos(shotPos[i])
		);
	end

	for (genvar j = 0; j < `NUM_BIRDS; j++) begin : genBirds
		birdLogic #(
			.START_X(videoPkg::coord_t'(birdX0 + j * birdDX)),
			.START_Y(videoPkg::coord_t'(`BIRD_Y0 + j * `BIRD_DY))
		) bird (
			.clk,
			.reset,
			.frameStart,
			.kill(birdKill[j]),
			.pos(birdPos[j])
		);
	end

	spriteRenderer renderer (
		.clk,
		.reset,
		.active,
		.pixel,
		.player(playerPos),
		.shots(shotPos),
		.birds(birdPos),
		.shotHit,
		.birdHit,
		.rgb
	);

	collisionDetect collision (
		.clk, .reset, .frameStart, .active, .shotHit, .birdHit, .shotKill, .birdKill, .scoreInc
	);

	// ====================
	// Firing and score
	assign shootEdge = controls.shoot && !shootLast;
	assign deploy = (freeShots & (~freeShots + 1'b1)) & {`NUM_SHOTS{frameStart && shootEdge}};

	always_ff @(posedge clk) begin
		if (reset) begin
			shootLast <= 1'b0;
			score <= '0;
		end else if (frameStart) begin
			shootLast <= controls.shoot; // Button is only looked at once a frame
			score <= score + {6'b0, scoreInc};
		end
	end

	// Sync and blank pass through one register to line up with the registered colour
	always_ff @(posedge clk) begin
		if (reset) begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			blank <= 1'b0;
		end else begin
			hsync <= hsyncRaw;
			vsync <= vsyncRaw;
			blank <= active;
		end
	end

endmodule

`default_nettype wire

//--- src/game_defs.svh
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// ====================
// Frame geometry
`define H_ACTIVE 64
`define H_TOTAL 80
`define HSYNC_START 68
`define HSYNC_END 74
`define V_ACTIVE 48
`define V_TOTAL 52
`define VSYNC_START 49
`define VSYNC_END 51

// ====================
// Objects
`define OBJ_SIZE 4
`define SHOT_W 1
`define SHOT_H 2
`define PLAYER_Y (`V_ACTIVE - 6)
`define PLAYER_START_X 30
`define PLAYER_STEP 2
`define SHOT_STEP 3
`define NUM_SHOTS 2
`define NUM_BIRDS 2
`define BIRD_STEP 1
`define BIRD_Y0 8
`define BIRD_DY 10

`endif

//--- src/playerLogic.sv
`timescale 1ns/1ns
`default_nettype none
`include "game_defs.svh"

module playerLogic (
	input logic clk,
	input logic reset,
	input logic frameStart,
	input gamePkg::controls_t controls,
	output gamePkg::objPos_t pos
);

	localparam videoPkg::coord_t step = videoPkg::coord_t'(`PLAYER_STEP);
	localparam videoPkg::coord_t maxX = videoPkg::coord_t'(`H_ACTIVE - `OBJ_SIZE);
	localparam videoPkg::coord_t startX = videoPkg::coord_t'(`PLAYER_START_X);
	localparam videoPkg::coord_t playerY = videoPkg::coord_t'(`PLAYER_Y);

	videoPkg::coord_t x;
	videoPkg::coord_t nextX;

	always_comb begin
		nextX = x;
		if (controls.left && !controls.right)
			nextX = x - step;
		else if (controls.right && !controls.left)
			nextX = x + step;
		// Keep the whole square on screen
		if (nextX < 11'sd0)
			nextX = 11'sd0;
		else if (nextX > maxX)
			nextX = maxX;
	end

	always_ff @(posedge clk) begin
		if (reset)
			x <= startX;
		else if (frameStart)
			x <= nextX;
	end

	assign pos = '{active: 1'b1, xy: '{x: x, y: playerY}};

endmodule

`default_nettype wire

//--- src/shotLogic.sv
`timescale 1ns/1ns
`default_nettype none
`include "game_defs.svh"

module shotLogic (
	input logic clk,
	input logic reset,
	input logic frameStart,
	input logic deploy,
	input logic kill,
	input gamePkg::objPos_t playerPos,
	output gamePkg::objPos_t pos
);

	localparam videoPkg::coord_t step = videoPkg::coord_t'(`SHOT_STEP);
	localparam videoPkg::coord_t noseOffset = videoPkg::coord_t'(`OBJ_SIZE / 2);
	localparam videoPkg::coord_t startY = videoPkg::coord_t'(`PLAYER_Y - `SHOT_H);

	gamePkg::objState_t state;
	videoPkg::coord_t x;
	videoPkg::coord_t y;
	videoPkg::coord_t nextY;

	assign nextY = y - step;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= gamePkg::IDLE;
		end else if (frameStart) begin
			unique case (state)
				gamePkg::IDLE: begin
					if (deploy) begin
						state <= gamePkg::ACTIVE;
						x <= playerPos.xy.x + noseOffset; // Centre of the player
						y <= startY;
					end
				end
				gamePkg::ACTIVE: begin
					if (kill || nextY < 11'sd0)
						state <= gamePkg::IDLE; // A kill wins over the move
					else
						y <= nextY;
				end
			endcase
		end
	end

	assign pos = '{active: (state == gamePkg::ACTIVE), xy: '{x: x, y: y}};

endmodule

`default_nettype wire

//--- src/spriteRenderer.sv
`timescale 1ns/1ns
`default_nettype none
`include "game_defs.svh"

module spriteRenderer (
	input logic clk,
	input logic reset,
	input logic active,
	input videoPkg::pixelPos_t pixel,
	input gamePkg::objPos_t player,
	input gamePkg::objPos_t [`NUM_SHOTS-1:0] shots,
	input gamePkg::objPos_t [`NUM_BIRDS-1:0] birds,
	output logic [`NUM_SHOTS-1:0] shotHit,
	output logic [`NUM_BIRDS-1:0] birdHit,
	output videoPkg::rgb_t rgb
);

	localparam videoPkg::coord_t objSize = videoPkg::coord_t'(`OBJ_SIZE);
	localparam videoPkg::coord_t shotW = videoPkg::coord_t'(`SHOT_W);
	localparam videoPkg::coord_t shotH = videoPkg::coord_t'(`SHOT_H);

	logic playerReq;
	gamePkg::objKind_t layer;

	function automatic logic insideBox(
		input gamePkg::objPos_t obj,
		input videoPkg::pixelPos_t p,
		input videoPkg::coord_t w,
		input videoPkg::coord_t h
	);
		return obj.active
			&& (p.x >= obj.xy.x) && (p.x < obj.xy.x + w)
			&& (p.y >= obj.xy.y) && (p.y < obj.xy.y + h);
	endfunction

	// ====================
	// Drawing requests
	always_comb begin
		playerReq = insideBox(player, pixel, objSize, objSize);
		for (int i = 0; i < `NUM_SHOTS; i++)
			shotHit[i] = insideBox(shots[i], pixel, shotW, shotH);
		for (int j = 0; j < `NUM_BIRDS; j++)
			birdHit[j] = insideBox(birds[j], pixel, objSize, objSize);

		// Shots are drawn on top of everything
		if (|shotHit)
			layer = gamePkg::SHOT;
		else if (|birdHit)
			layer = gamePkg::BIRD;
		else if (playerReq)
			layer = gamePkg::PLAYER;
		else
			layer = gamePkg::NONE;
	end

	// ====================
	// Colour output
	always_ff @(posedge clk) begin
		if (reset || !active) begin
			rgb <= '0; // Black while blanking
		end else begin
			unique case (layer)
				gamePkg::SHOT: rgb <= videoPkg::COLOR_SHOT;
				gamePkg::BIRD: rgb <= videoPkg::COLOR_BIRD;
				gamePkg::PLAYER: rgb <= videoPkg::COLOR_PLAYER;
				gamePkg::NONE: rgb <= videoPkg::COLOR_BG;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/vgaTiming.sv
`timescale 1ns/1ns
`default_nettype none
`include "game_defs.svh"

module vgaTiming (
	input logic clk,
	input logic reset,
	output videoPkg::pixelPos_t pixel,
	output logic active,
	output logic hsyncRaw,
	output logic vsyncRaw,
	output logic frameStart
);

	localparam logic [10:0] hLast = 11'(`H_TOTAL - 1);
	localparam logic [10:0] vLast = 11'(`V_TOTAL - 1);
	localparam logic [10:0] hActive = 11'(`H_ACTIVE);
	localparam logic [10:0] vActive = 11'(`V_ACTIVE);
	localparam logic [10:0] hSyncStart = 11'(`HSYNC_START);
	localparam logic [10:0] hSyncEnd = 11'(`HSYNC_END);
	localparam logic [10:0] vSyncStart = 11'(`VSYNC_START);
	localparam logic [10:0] vSyncEnd = 11'(`VSYNC_END);

	logic [10:0] hCount;
	logic [10:0] vCount;

	always_ff @(posedge clk) begin
		if (reset) begin
			hCount <= '0;
			vCount <= '0;
		end else if (hCount == hLast) begin
			hCount <= '0;
			vCount <= (vCount == vLast) ? '0 : vCount + 1'b1; // End of line
		end else begin
			hCount <= hCount + 1'b1;
		end
	end

	assign pixel = '{x: $signed(hCount), y: $signed(vCount)};
	assign active = (hCount < hActive) && (vCount < vActive);

	// Both syncs are active low
	assign hsyncRaw = !((hCount >= hSyncStart) && (hCount < hSyncEnd));
	assign vsyncRaw = !((vCount >= vSyncStart) && (vCount < vSyncEnd));

	assign frameStart = (vCount == vActive) && (hCount == '0); // First blank line

endmodule

`default_nettype wire

//--- src/videoPkg.sv
`default_nettype none

package videoPkg;

	typedef logic signed [10:0] coord_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} pixelPos_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// Background is never black, so blanking stays visible
	localparam rgb_t COLOR_BG = '{r: 8'h10, g: 8'h20, b: 8'h5c};
	localparam rgb_t COLOR_PLAYER = '{r: 8'h20, g: 8'hd0, b: 8'h30};
	localparam rgb_t COLOR_SHOT = '{r: 8'hff, g: 8'hf0, b: 8'h40};
	localparam rgb_t COLOR_BIRD = '{r: 8'hc0, g: 8'h30, b: 8'h20};

endpackage

`default_nettype wire

//--- tests/gameTopTb.sv
`timescale 1ns/1ns
`default_nettype none
`include "game_defs.svh"

module gameTopTb;

	localparam int clkPeriod = 20;
	localparam int lineCycles = `H_TOTAL;
	localparam int frameCycles = `H_TOTAL * `V_TOTAL;
	localparam int waitLimit = 2 * frameCycles;
	localparam int numRows = 50;
	localparam int numRandom = 30;
	localparam int birdX0 = 8; // Bird start columns as placed by gameTop
	localparam int birdDX = 28;

	localparam gamePkg::controls_t idle = 3'b000;
	localparam gamePkg::controls_t goLeft = 3'b100;
	localparam gamePkg::controls_t goRight = 3'b010;
	localparam gamePkg::controls_t both = 3'b110;
	localparam gamePkg::controls_t fire = 3'b001;
	localparam gamePkg::controls_t leftFire = 3'b101;

	// Expected values are what the frame shows while the row's controls are held
	typedef struct packed {
		gamePkg::controls_t ctrl;
		logic [7:0] expX;
		logic [7:0] expScore;
	} row_t;

	logic clk;
	logic reset;
	gamePkg::controls_t controls;
	videoPkg::rgb_t rgb;
	logic hsync;
	logic vsync;
	logic blank;
	logic [7:0] score;

	row_t rows [numRows];
	int errors = 0;
	int checks = 0;
	bit timedOut = 1'b0;
	int cycleCount = 0;
	int lastFall = -1;
	logic [7:0] lfsr;

	// ====================
	// Reference model state
	int modelX;
	int modelScore;
	bit modelShootLast;
	bit shotOn [`NUM_SHOTS];
	int shotX [`NUM_SHOTS];
	int shotY [`NUM_SHOTS];
	int birdX [`NUM_BIRDS];
	bit birdRight [`NUM_BIRDS];

	gameTop dut (.clk, .reset, .controls, .rgb, .hsync, .vsync, .blank, .score);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = !clk;
	end

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	task automatic checkEq(input int got, input int expected, input string what);
		checks++;
		if (got != expected) begin
			errors++;
			$display("[FAIL] %0t ns: %s: got %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	// 8-bit Fibonacci LFSR with taps 8 6 5 4
	function automatic logic [7:0] lfsrNext(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic randomBit(output logic b);
		lfsr = lfsrNext(lfsr);
		b = lfsr[0];
	endtask

	function automatic bit covers(int px, int py, int ox, int oy, int w, int h);
		return px >= ox && px < ox + w && py >= oy && py < oy + h;
	endfunction

	function automatic bit overlaps(int sx, int sy, int bx, int by);
		return sx < bx + `OBJ_SIZE && sx + `SHOT_W > bx
			&& sy < by + `OBJ_SIZE && sy + `SHOT_H > by;
	endfunction

	function automatic int birdY(int j);
		return `BIRD_Y0 + j * `BIRD_DY;
	endfunction

	// Shots are drawn over birds, birds over the player
	function automatic videoPkg::rgb_t expectedColour(int x, int y);
		videoPkg::rgb_t c;
		c = videoPkg::COLOR_BG;
		if (covers(x, y, modelX, `PLAYER_Y, `OBJ_SIZE, `OBJ_SIZE))
			c = videoPkg::COLOR_PLAYER;
		for (int j = 0; j < `NUM_BIRDS; j++)
			if (covers(x, y, birdX[j], birdY(j), `OBJ_SIZE, `OBJ_SIZE))
				c = videoPkg::COLOR_BIRD;
		for (int i = 0; i < `NUM_SHOTS; i++)
			if (shotOn[i] && covers(x, y, shotX[i], shotY[i], `SHOT_W, `SHOT_H))
				c = videoPkg::COLOR_SHOT;
		return c;
	endfunction

	task automatic resetModel();
		modelX = `PLAYER_START_X;
		modelScore = 0;
		modelShootLast = 1'b0;
		for (int i = 0; i < `NUM_SHOTS; i++) begin
			shotOn[i] = 1'b0;
			shotX[i] = 0;
			shotY[i] = 0;
		end
		for (int j = 0; j < `NUM_BIRDS; j++) begin
			birdX[j] = birdX0 + j * birdDX;
			birdRight[j] = 1'b1;
		end
	endtask

	// A frame start applies the hits of the shown frame and then firing and motion
	task automatic stepModel(input gamePkg::controls_t c);
		bit shotKill [`NUM_SHOTS];
		bit birdKill [`NUM_BIRDS];
		bit deployDone;
		int nextX;
		for (int i = 0; i < `NUM_SHOTS; i++)
			shotKill[i] = 1'b0;
		for (int j = 0; j < `NUM_BIRDS; j++)
			birdKill[j] = 1'b0;
		for (int i = 0; i < `NUM_SHOTS; i++)
			for (int j = 0; j < `NUM_BIRDS; j++)
				if (shotOn[i] && overlaps(shotX[i], shotY[i], birdX[j], birdY(j))) begin
					shotKill[i] = 1'b1;
					birdKill[j] = 1'b1;
				end

		deployDone = !(c.shoot && !modelShootLast); // Only a new press fires
		for (int i = 0; i < `NUM_SHOTS; i++) begin
			if (!shotOn[i]) begin
				if (!deployDone) begin
					shotOn[i] = 1'b1;
					shotX[i] = modelX + `OBJ_SIZE / 2;
					shotY[i] = `PLAYER_Y - `SHOT_H;
					deployDone = 1'b1;
				end
			end else if (shotKill[i] || shotY[i] - `SHOT_STEP < 0) begin
				shotOn[i] = 1'b0;
			end else begin
				shotY[i] = shotY[i] - `SHOT_STEP;
			end
		end

		for (int j = 0; j < `NUM_BIRDS; j++) begin
			if (birdKill[j]) begin
				birdX[j] = birdX0 + j * birdDX;
				birdRight[j] = 1'b1;
				modelScore = (modelScore + 1) % 256;
			end else begin
				nextX = birdRight[j] ? birdX[j] + `BIRD_STEP : birdX[j] - `BIRD_STEP;
				if (nextX < 0 || nextX > `H_ACTIVE - `OBJ_SIZE)
					birdRight[j] = !birdRight[j]; // Turn and hold
				else
					birdX[j] = nextX;
			end
		end

		if (c.left && !c.right)
			modelX = modelX - `PLAYER_STEP;
		else if (c.right && !c.left)
			modelX = modelX + `PLAYER_STEP;
		if (modelX < 0)
			modelX = 0;
		else if (modelX > `H_ACTIVE - `OBJ_SIZE)
			modelX = `H_ACTIVE - `OBJ_SIZE;
		modelShootLast = c.shoot;
	endtask

	// ====================
	// Waits and frame capture
	task automatic waitSyncFall(input bit useVsync, output int cycles);
		bit seen;
		logic prev;
		logic cur;
		seen = 1'b0;
		cycles = 0;
		prev = useVsync ? vsync : hsync;
		while (!seen && cycles < waitLimit) begin
			@(negedge clk);
			cycles++;
			cur = useVsync ? vsync : hsync;
			seen = prev && !cur;
			prev = cur;
		end
		if (!seen) begin
			$display("Timeout: %s did not fall within %0d cycles", useVsync ? "vsync" : "hsync",
				waitLimit);
			timedOut = 1'b1;
		end
	endtask

	task automatic waitBlankHigh();
		int n;
		n = 0;
		while (!blank && n < waitLimit) begin
			@(negedge clk);
			n++;
		end
		if (!blank) begin
			$display("Timeout: blank did not rise within %0d cycles", waitLimit);
			timedOut = 1'b1;
		end
	endtask

	// The first sample is pixel (0, 0) of the visible area
	task automatic checkFrame(input int row, output int playerCol);
		int x;
		int y;
		int pixErrors;
		int blankErrors;
		videoPkg::rgb_t want;
		pixErrors = 0;
		blankErrors = 0;
		playerCol = -1;
		for (int c = 0; c < `V_ACTIVE * `H_TOTAL; c++) begin
			if (c > 0)
				@(negedge clk);
			x = c % `H_TOTAL;
			y = c / `H_TOTAL;
			if (blank != (x < `H_ACTIVE))
				blankErrors++;
			want = (x < `H_ACTIVE) ? expectedColour(x, y) : '0; // Black outside the picture
			if (rgb != want)
				pixErrors++;
			if (y == `PLAYER_Y && playerCol < 0 && rgb == videoPkg::COLOR_PLAYER)
				playerCol = x;
		end
		checkEq(blankErrors, 0, $sformatf("blank errors in frame %0d", row));
		checkEq(pixErrors, 0, $sformatf("pixels differing from the model in frame %0d", row));
	endtask

	task automatic runFrame(input gamePkg::controls_t c, input int row, input int wantX,
			input int wantScore);
		int cycles;
		int col;
		waitSyncFall(1'b1, cycles);
		if (timedOut)
			return;
		if (lastFall >= 0)
			checkEq(cycleCount - lastFall, frameCycles, "frame period in cycles");
		lastFall = cycleCount;
		controls = c; // Sampled at the next frame start
		waitBlankHigh();
		if (timedOut)
			return;
		checkFrame(row, col);
		checkEq(col, modelX, $sformatf("player column in frame %0d", row));
		checkEq(int'(score), modelScore, $sformatf("score in frame %0d", row));
		if (wantX >= 0) begin
			checkEq(col, wantX, $sformatf("player column from table row %0d", row));
			checkEq(int'(score), wantScore, $sformatf("score from table row %0d", row));
		end
		stepModel(c);
	endtask

	// ====================
	// Main sequence
	initial begin
		int cycles;
		gamePkg::controls_t pick;
		reset = 1'b1;
		controls = idle;
		lfsr = 8'd24;
		rows = '{
			'{goRight, 8'd30, 8'd0}, '{goRight, 8'd32, 8'd0}, '{goRight, 8'd34, 8'd0},
			'{goRight, 8'd36, 8'd0}, '{goRight, 8'd38, 8'd0}, '{goRight, 8'd40, 8'd0},
			'{goRight, 8'd42, 8'd0}, '{goRight, 8'd44, 8'd0}, '{goRight, 8'd46, 8'd0},
			'{goRight, 8'd48, 8'd0}, '{goRight, 8'd50, 8'd0}, '{goRight, 8'd52, 8'd0},
			'{goRight, 8'd54, 8'd0}, '{fire, 8'd56, 8'd0}, '{goRight, 8'd56, 8'd0},
			'{goRight, 8'd58, 8'd0}, '{goRight, 8'd60, 8'd0}, '{both, 8'd60, 8'd0},
			'{leftFire, 8'd60, 8'd0}, '{goLeft, 8'd58, 8'd0}, '{leftFire, 8'd56, 8'd0},
			'{goLeft, 8'd54, 8'd0}, '{goLeft, 8'd52, 8'd1}, '{goLeft, 8'd50, 8'd1},
			'{goLeft, 8'd48, 8'd1}, '{goLeft, 8'd46, 8'd1}, '{goLeft, 8'd44, 8'd1},
			'{goLeft, 8'd42, 8'd1}, '{goLeft, 8'd40, 8'd1}, '{goLeft, 8'd38, 8'd1},
			'{goLeft, 8'd36, 8'd1}, '{goLeft, 8'd34, 8'd1}, '{goLeft, 8'd32, 8'd1},
			'{goLeft, 8'd30, 8'd1}, '{goLeft, 8'd28, 8'd1}, '{goLeft, 8'd26, 8'd1},
			'{goLeft, 8'd24, 8'd1}, '{goLeft, 8'd22, 8'd1}, '{goLeft, 8'd20, 8'd1},
			'{goLeft, 8'd18, 8'd1}, '{goLeft, 8'd16, 8'd1}, '{goLeft, 8'd14, 8'd1},
			'{goLeft, 8'd12, 8'd1}, '{goLeft, 8'd10, 8'd1}, '{goLeft, 8'd8, 8'd1},
			'{goLeft, 8'd6, 8'd1}, '{goLeft, 8'd4, 8'd1}, '{goLeft, 8'd2, 8'd1},
			'{goLeft, 8'd0, 8'd1}, '{idle, 8'd0, 8'd1}
		};
		resetModel();
		repeat (4) @(negedge clk);
		reset = 1'b0;

		waitSyncFall(1'b0, cycles);
		if (!timedOut) begin
			waitSyncFall(1'b0, cycles);
			checkEq(cycles, lineCycles, "hsync period in cycles");
		end

		stepModel(idle); // First frame start comes before the first row
		for (int r = 0; r < numRows && !timedOut; r++)
			runFrame(rows[r].ctrl, r, int'(rows[r].expX), int'(rows[r].expScore));
		for (int r = 0; r < numRandom && !timedOut; r++) begin
			randomBit(pick.left);
			randomBit(pick.right);
			randomBit(pick.shoot);
			runFrame(pick, numRows + r, -1, -1);
		end

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, int'(timedOut));
		if (errors == 0 && !timedOut)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
